//--- src/cachePkg.sv
// Shared widths and types for the two-way set-associative data cache
// Address layout is fixed here so the address union has a known shape
package cachePkg;

    // Geometry of the cache and its buses
    localparam int addrBits = 32;
    localparam int wordBits = 64;
    localparam int wordsPerLine = 8;
    localparam int byteOffsetBits = 3;
    localparam int wordSelBits = 3;
    localparam int indexBits = 4;
    localparam int tagBits = addrBits - indexBits - wordSelBits - byteOffsetBits;

    typedef logic [addrBits-1:0] addrT;
    typedef logic [wordBits-1:0] wordT;
    // Word 0 sits at the low end of the line
    typedef logic [wordsPerLine*wordBits-1:0] lineT;
    typedef logic [tagBits-1:0] tagT;
    typedef logic [indexBits-1:0] indexT;
    typedef logic [wordSelBits-1:0] wordSelT;
    typedef logic wayT;

    // Address split, high bits first
    typedef struct packed {
        tagT tag;
        indexT index;
        wordSelT wordSel;
        logic [byteOffsetBits-1:0] byteOffset;
    } cacheAddrFieldsT;

    // Same 32 bits seen as a raw byte address or as cache fields
    typedef union packed {
        addrT raw;
        cacheAddrFieldsT fields;
    } cacheAddrU;

endpackage

//--- src/cacheIfs.sv
// Internal links of the data cache
// coreIf carries the accepted request and the response word
// fillIf carries a line fill request and the assembled line

interface coreIf;

    // Request side, from the core port
    logic reqValid;
    cachePkg::cacheAddrU reqAddr;

    // Response side, from the controller
    logic respValid;
    cachePkg::wordT respWord;

    modport port (
        output reqValid,
        output reqAddr,
        input respValid,
        input respWord
    );

    modport ctrl (
        input reqValid,
        input reqAddr,
        output respValid,
        output respWord
    );

endinterface

interface fillIf;

    // Start strobe and the missing address
    logic fillStart;
    cachePkg::cacheAddrU fillAddr;

    // Completion strobe, line valid with it
    logic fillDone;
    cachePkg::lineT fillLine;

    modport ctrl (
        output fillStart,
        output fillAddr,
        input fillDone,
        input fillLine
    );

    modport fetch (
        input fillStart,
        input fillAddr,
        output fillDone,
        output fillLine
    );

endinterface

//--- src/coreSidePort.sv
// Core side of the cache
// Accepts one read at a time, acknowledges it and registers the response

module coreSidePort (
    input logic rwArbiterCacheBus,
    input logic reset,
    input logic reqCyc,
    input cachePkg::addrT reqAddr,
    output logic reqAck,
    output logic respCyc,
    output cachePkg::wordT respData,
    coreIf.port core
);

    // Set while a request is open
    logic busy;
    logic accept;

    // New requests only between accesses
    assign accept = reqCyc && !busy;

    // Control flops
    always_ff @(posedge rwArbiterCacheBus) begin
        if (reset) begin
            busy <= 1'b0;
            reqAck <= 1'b0;
            core.reqValid <= 1'b0;
            respCyc <= 1'b0;
        end else begin
            // Ack and internal strobe go out together
            reqAck <= accept;
            core.reqValid <= accept;
            if (accept) begin
                busy <= 1'b1;
            end else if (core.respValid) begin
                busy <= 1'b0;
            end
            respCyc <= core.respValid;
        end
    end

    // Address and response payload
    always_ff @(posedge rwArbiterCacheBus) begin
        if (accept) begin
            // Held stable until the response
            core.reqAddr.raw <= reqAddr;
        end
        if (core.respValid) begin
            respData <= core.respWord;
        end
    end

endmodule

//--- src/cacheController.sv
// Lookup and fill sequencing of the two-way cache
// Keeps the valid bits and the LRU way of every set

module cacheController (
    input logic rwArbiterCacheBus,
    input logic reset,
    coreIf.ctrl core,
    fillIf.ctrl fill,
    output logic tagRead,
    input logic tagReady,
    input cachePkg::tagT readTag0,
    input cachePkg::tagT readTag1,
    output logic tagWrite,
    output cachePkg::wayT writeWay,
    output cachePkg::tagT writeTag,
    output cachePkg::indexT index,
    output logic lineWrite,
    output cachePkg::lineT writeLine,
    output cachePkg::wayT hitWay,
    output cachePkg::wordSelT wordSel,
    input cachePkg::wordT readWord
);

    typedef enum logic [1:0] {
        stIdle,
        stLookup,
        stFill,
        stRespond
    } ctrlStateT;

    ctrlStateT state;
    cachePkg::cacheAddrU reqAddr;

    // Valid bit per way and set, LRU way per set
    logic [1:0][(1 << cachePkg::indexBits)-1:0] validBits;
    logic [(1 << cachePkg::indexBits)-1:0] lruWay;

    // Way being served, hit way or fill victim
    cachePkg::wayT wayReg;
    logic anyValid;
    logic hit0;
    logic hit1;
    logic fillEnd;

    assign reqAddr = core.reqAddr;
    assign index = reqAddr.fields.index;
    assign wordSel = reqAddr.fields.wordSel;
    assign fill.fillAddr = reqAddr;

    assign anyValid = validBits[0][index] || validBits[1][index];
    // Tag compare only counts on a valid way
    assign hit0 = validBits[0][index] && (readTag0 == reqAddr.fields.tag);
    assign hit1 = validBits[1][index] && (readTag1 == reqAddr.fields.tag);
    assign hitWay = hit1;

    // Skip the tag read when the set is empty
    assign tagRead = (state == stIdle) && core.reqValid && anyValid;

    // Line and tag go in on the same cycle
    assign fillEnd = (state == stFill) && fill.fillDone;
    assign lineWrite = fillEnd;
    assign tagWrite = fillEnd;
    assign writeWay = wayReg;
    assign writeTag = reqAddr.fields.tag;
    assign writeLine = fill.fillLine;

    assign core.respValid = (state == stRespond);

    always_ff @(posedge rwArbiterCacheBus) begin
        if (reset) begin
            state <= stIdle;
            validBits <= '0;
            // Way 0 is the first victim everywhere
            lruWay <= '0;
            fill.fillStart <= 1'b0;
        end else begin
            fill.fillStart <= 1'b0;
            case (state)
                stIdle: begin
                    if (core.reqValid) begin
                        if (anyValid) begin
                            state <= stLookup;
                        end else begin
                            wayReg <= lruWay[index];
                            fill.fillStart <= 1'b1;
                            state <= stFill;
                        end
                    end
                end
                stLookup: begin
                    if (tagReady) begin
                        if (hit0 || hit1) begin
                            wayReg <= hitWay;
                            core.respWord <= readWord;
                            state <= stRespond;
                        end else begin
                            // Miss, replace the LRU way
                            wayReg <= lruWay[index];
                            fill.fillStart <= 1'b1;
                            state <= stFill;
                        end
                    end
                end
                stFill: begin
                    if (fill.fillDone) begin
                        validBits[wayReg][index] <= 1'b1;
                        core.respWord <= fill.fillLine[wordSel*cachePkg::wordBits +:
                            cachePkg::wordBits];
                        state <= stRespond;
                    end
                end
                stRespond: begin
                    // Served way becomes most recently used
                    lruWay[index] <= ~wayReg;
                    state <= stIdle;
                end
                default: state <= stIdle;
            endcase
        end
    end

endmodule

//--- src/tagStore.sv
// Tag arrays for both ways
// Reads are delayed by sramLatency cycles and flagged with tagReady

module tagStore #(
    parameter int sramLatency = 2
) (
    input logic rwArbiterCacheBus,
    input logic reset,
    input cachePkg::indexT index,
    input logic tagRead,
    input logic tagWrite,
    input cachePkg::wayT writeWay,
    input cachePkg::tagT writeTag,
    output cachePkg::tagT readTag0,
    output cachePkg::tagT readTag1,
    output logic tagReady
);

    localparam int cntBits = $clog2(sramLatency + 1);

    cachePkg::tagT tagWay0 [0:(1 << cachePkg::indexBits)-1];
    cachePkg::tagT tagWay1 [0:(1 << cachePkg::indexBits)-1];

    // Zero means no read in progress
    logic [cntBits-1:0] waitCount;

    always_ff @(posedge rwArbiterCacheBus) begin
        if (reset) begin
            waitCount <= '0;
        end else if (tagRead) begin
            waitCount <= cntBits'(sramLatency);
        end else if (waitCount != '0) begin
            waitCount <= waitCount - 1'b1;
        end
    end

    // Last count of the delay
    assign tagReady = (waitCount == cntBits'(1));

    // Registered read like a sync SRAM, index is stable during lookup
    always_ff @(posedge rwArbiterCacheBus) begin
        readTag0 <= tagWay0[index];
        readTag1 <= tagWay1[index];
        if (tagWrite) begin
            if (writeWay) begin
                tagWay1[index] <= writeTag;
            end else begin
                tagWay0[index] <= writeTag;
            end
        end
    end

endmodule

//--- src/dataStore.sv
// Line storage for both ways
// Whole-line writes on fill, single-word reads from the hit way

module dataStore (
    input logic rwArbiterCacheBus,
    input cachePkg::indexT index,
    input logic lineWrite,
    input cachePkg::wayT writeWay,
    input cachePkg::lineT writeLine,
    input cachePkg::wayT hitWay,
    input cachePkg::wordSelT wordSel,
    output cachePkg::wordT readWord
);

    cachePkg::lineT lineWay0 [0:(1 << cachePkg::indexBits)-1];
    cachePkg::lineT lineWay1 [0:(1 << cachePkg::indexBits)-1];

    cachePkg::lineT selLine;

    // All eight words written at once
    always_ff @(posedge rwArbiterCacheBus) begin
        if (lineWrite) begin
            if (writeWay) begin
                lineWay1[index] <= writeLine;
            end else begin
                lineWay0[index] <= writeLine;
            end
        end
    end

    // Combinational word pick
    assign selLine = hitWay ? lineWay1[index] : lineWay0[index];
    assign readWord = selLine[wordSel*cachePkg::wordBits +: cachePkg::wordBits];

endmodule

//--- src/lineFetcher.sv
// Memory side of the cache
// Requests one line and gathers its eight word beats

module lineFetcher (
    input logic rwArbiterCacheBus,
    input logic reset,
    fillIf.fetch fetch,
    output logic memReqCyc,
    output cachePkg::addrT memReqAddr,
    input logic memReqAck,
    input logic memRespCyc,
    input cachePkg::wordT memRespData
);

    cachePkg::cacheAddrU alignedAddr;
    cachePkg::lineT lineReg;
    cachePkg::wordSelT beatCount;
    logic collecting;

    // Clear word select and byte offset for the line address
    always_comb begin
        alignedAddr = fetch.fillAddr;
        alignedAddr.fields.wordSel = '0;
        alignedAddr.fields.byteOffset = '0;
    end

    always_ff @(posedge rwArbiterCacheBus) begin
        if (reset) begin
            memReqCyc <= 1'b0;
            collecting <= 1'b0;
            beatCount <= '0;
            fetch.fillDone <= 1'b0;
        end else begin
            fetch.fillDone <= 1'b0;
            // Request held until memory acks
            if (fetch.fillStart) begin
                memReqCyc <= 1'b1;
                collecting <= 1'b1;
                beatCount <= '0;
            end else if (memReqCyc && memReqAck) begin
                memReqCyc <= 1'b0;
            end
            if (collecting && memRespCyc) begin
                beatCount <= beatCount + 1'b1;
                if (beatCount == cachePkg::wordSelT'(cachePkg::wordsPerLine - 1)) begin
                    collecting <= 1'b0;
                    fetch.fillDone <= 1'b1;
                end
            end
        end
    end

    // Address and line payload
    always_ff @(posedge rwArbiterCacheBus) begin
        if (fetch.fillStart) begin
            memReqAddr <= alignedAddr.raw;
        end
        if (collecting && memRespCyc) begin
            lineReg[beatCount*cachePkg::wordBits +: cachePkg::wordBits] <= memRespData;
        end
    end

    assign fetch.fillLine = lineReg;

endmodule

//--- src/setAssocDataCache.sv
// Two-way set-associative read-only data cache
// Core port, controller, tag and data stores, and memory line fetcher

module setAssocDataCache #(
    parameter int sramLatency = 2
) (
    input logic rwArbiterCacheBus,
    input logic reset,
    input logic reqCyc,
    input cachePkg::addrT reqAddr,
    output logic reqAck,
    output logic respCyc,
    output cachePkg::wordT respData,
    output logic memReqCyc,
    output cachePkg::addrT memReqAddr,
    input logic memReqAck,
    input logic memRespCyc,
    input cachePkg::wordT memRespData
);

    coreIf coreBus ();
    fillIf fillBus ();

    // Controller to tag store
    logic tagRead;
    logic tagReady;
    logic tagWrite;
    cachePkg::tagT readTag0;
    cachePkg::tagT readTag1;
    cachePkg::tagT writeTag;
    cachePkg::wayT writeWay;
    cachePkg::indexT index;

    // Controller to data store
    logic lineWrite;
    cachePkg::lineT writeLine;
    cachePkg::wayT hitWay;
    cachePkg::wordSelT wordSel;
    cachePkg::wordT readWord;

    coreSidePort corePort (
        .rwArbiterCacheBus(rwArbiterCacheBus), .reset(reset),
        .reqCyc(reqCyc), .reqAddr(reqAddr), .reqAck(reqAck),
        .respCyc(respCyc), .respData(respData), .core(coreBus.port)
    );

    cacheController ctrl (
        .rwArbiterCacheBus(rwArbiterCacheBus), .reset(reset),
        .core(coreBus.ctrl), .fill(fillBus.ctrl),
        .tagRead(tagRead), .tagReady(tagReady), .readTag0(readTag0), .readTag1(readTag1),
        .tagWrite(tagWrite), .writeWay(writeWay), .writeTag(writeTag), .index(index),
        .lineWrite(lineWrite), .writeLine(writeLine), .hitWay(hitWay),
        .wordSel(wordSel), .readWord(readWord)
    );

    tagStore #(.sramLatency(sramLatency)) tags (
        .rwArbiterCacheBus(rwArbiterCacheBus), .reset(reset), .index(index),
        .tagRead(tagRead), .tagWrite(tagWrite), .writeWay(writeWay), .writeTag(writeTag),
        .readTag0(readTag0), .readTag1(readTag1), .tagReady(tagReady)
    );

    dataStore lines (
        .rwArbiterCacheBus(rwArbiterCacheBus), .index(index), .lineWrite(lineWrite),
        .writeWay(writeWay), .writeLine(writeLine), .hitWay(hitWay),
        .wordSel(wordSel), .readWord(readWord)
    );

    lineFetcher fetcher (
        .rwArbiterCacheBus(rwArbiterCacheBus), .reset(reset), .fetch(fillBus.fetch),
        .memReqCyc(memReqCyc), .memReqAddr(memReqAddr), .memReqAck(memReqAck),
        .memRespCyc(memRespCyc), .memRespData(memRespData)
    );

endmodule

//--- verification/cacheMemModel.sv
// Memory responder for the cache testbench
// Acks line requests after a random delay and returns eight words with random gaps

module cacheMemModel (
    input logic rwArbiterCacheBus,
    input logic memReqCyc,
    input cachePkg::addrT memReqAddr,
    output logic memReqAck,
    output logic memRespCyc,
    output cachePkg::wordT memRespData
);

    timeunit 1ns;
    timeprecision 100ps;

    // Word address in the low half, its complement in the high half
    function automatic cachePkg::wordT memWord(input cachePkg::addrT addr);
        logic [31:0] wordAddr;
        wordAddr = {3'b000, addr[31:3]};
        return {~wordAddr, wordAddr};
    endfunction

    initial begin
        cachePkg::addrT lineAddr;
        // Fixed seed so the stall pattern repeats from run to run
        void'($urandom(32'h99d3f01d));
        memReqAck = 1'b0;
        memRespCyc = 1'b0;
        memRespData = '0;
        forever begin
            @(negedge rwArbiterCacheBus);
            if (memReqCyc) begin
                lineAddr = memReqAddr;
                // Ack after 0 to 3 idle cycles
                repeat ($urandom % 4) @(negedge rwArbiterCacheBus);
                memReqAck = 1'b1;
                @(negedge rwArbiterCacheBus);
                memReqAck = 1'b0;
                for (int beat = 0; beat < cachePkg::wordsPerLine; beat++) begin
                    // 0 to 2 idle cycles before each beat
                    repeat ($urandom % 3) @(negedge rwArbiterCacheBus);
                    memRespCyc = 1'b1;
                    memRespData = memWord(lineAddr + cachePkg::addrT'(beat * 8));
                    @(negedge rwArbiterCacheBus);
                    memRespCyc = 1'b0;
                end
            end
        end
    end

endmodule

//--- verification/cacheAssert_assert.sv
// Protocol assertions on the cache top-level ports
// Bound into setAssocDataCache

module cacheAssert (
    input logic rwArbiterCacheBus,
    input logic reset,
    input logic reqCyc,
    input cachePkg::addrT reqAddr,
    input logic respCyc,
    input logic memReqCyc,
    input cachePkg::addrT memReqAddr,
    input logic memReqAck
);

    timeunit 1ns;
    timeprecision 100ps;

    // Core reads are whole words
    reqAligned: assert property (@(posedge rwArbiterCacheBus) disable iff (reset)
        reqCyc |-> (reqAddr[2:0] == 3'b000))
        else $error("reqAddr not word aligned");

    // Response is a single-cycle strobe
    respPulse: assert property (@(posedge rwArbiterCacheBus) disable iff (reset)
        respCyc |=> !respCyc)
        else $error("respCyc longer than one cycle");

    // Memory request held steady until acked
    memReqHold: assert property (@(posedge rwArbiterCacheBus) disable iff (reset)
        (memReqCyc && !memReqAck) |=> (memReqCyc && $stable(memReqAddr)))
        else $error("memReqCyc or memReqAddr changed before memReqAck");

endmodule

bind setAssocDataCache cacheAssert checks (
    .rwArbiterCacheBus(rwArbiterCacheBus), .reset(reset), .reqCyc(reqCyc),
    .reqAddr(reqAddr), .respCyc(respCyc), .memReqCyc(memReqCyc),
    .memReqAddr(memReqAddr), .memReqAck(memReqAck)
);

//--- verification/tbSetAssocDataCache.sv
// Testbench for the two-way set-associative data cache
// Runs a read table through the DUT and checks data, hit pattern and fill address

module tbSetAssocDataCache;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clkPeriod = 20;
    localparam int resetCycles = 8;
    localparam int numSteps = 17;

    // One read, an optional reset before it, and whether it should hit
    typedef struct packed {
        cachePkg::addrT addr;
        bit doReset;
        bit expHit;
    } stepT;

    // Set 3 takes tags 1, 2 and 3 to exercise LRU, then sets 13 and 15
    stepT steps [0:numSteps-1] = '{
        '{32'h0000_04C8, 1'b0, 1'b0}, '{32'h0000_04F8, 1'b0, 1'b1},
        '{32'h0000_08D0, 1'b0, 1'b0}, '{32'h0000_04C0, 1'b0, 1'b1},
        '{32'h0000_08D8, 1'b0, 1'b1}, '{32'h0000_04E0, 1'b0, 1'b1},
        '{32'h0000_0CC8, 1'b0, 1'b0}, '{32'h0000_04C8, 1'b0, 1'b1},
        '{32'h0000_08C0, 1'b0, 1'b0}, '{32'h0000_0CC0, 1'b0, 1'b0},
        '{32'h0001_2340, 1'b0, 1'b0}, '{32'h0001_2378, 1'b0, 1'b1},
        '{32'h0001_2358, 1'b1, 1'b0}, '{32'h0000_0CC0, 1'b0, 1'b0},
        '{32'h0000_0CE8, 1'b0, 1'b1}, '{32'hFFFF_FFF8, 1'b0, 1'b0},
        '{32'hFFFF_FFC0, 1'b0, 1'b1}
    };

    logic rwArbiterCacheBus;
    logic reset;
    logic reqCyc;
    cachePkg::addrT reqAddr;
    logic reqAck;
    logic respCyc;
    cachePkg::wordT respData;
    logic memReqCyc;
    cachePkg::addrT memReqAddr;
    logic memReqAck;
    logic memRespCyc;
    cachePkg::wordT memRespData;

    setAssocDataCache #(.sramLatency(2)) uut (
        .rwArbiterCacheBus(rwArbiterCacheBus), .reset(reset), .reqCyc(reqCyc),
        .reqAddr(reqAddr), .reqAck(reqAck), .respCyc(respCyc), .respData(respData),
        .memReqCyc(memReqCyc), .memReqAddr(memReqAddr), .memReqAck(memReqAck),
        .memRespCyc(memRespCyc), .memRespData(memRespData)
    );

    cacheMemModel memory (
        .rwArbiterCacheBus(rwArbiterCacheBus), .memReqCyc(memReqCyc),
        .memReqAddr(memReqAddr), .memReqAck(memReqAck), .memRespCyc(memRespCyc),
        .memRespData(memRespData)
    );

    initial begin
        rwArbiterCacheBus = 1'b0;
        forever #(clkPeriod / 2) rwArbiterCacheBus = ~rwArbiterCacheBus;
    end

    // Memory contents rule, word address low and its complement high
    function automatic cachePkg::wordT expectedWord(input cachePkg::addrT addr);
        logic [31:0] wordAddr;
        wordAddr = {3'b000, addr[31:3]};
        return {~wordAddr, wordAddr};
    endfunction

    function automatic cachePkg::addrT lineAddress(input cachePkg::addrT addr);
        cachePkg::cacheAddrU split;
        split.raw = addr;
        split.fields.wordSel = '0;
        split.fields.byteOffset = '0;
        return split.raw;
    endfunction

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input cachePkg::wordT got,
                             input cachePkg::wordT exp);
        if (got !== exp) begin
            failRun($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic checkAddr(input string name, input cachePkg::addrT got,
                             input cachePkg::addrT exp);
        if (got !== exp) begin
            failRun($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic checkHit(input bit got, input bit exp);
        if (got !== exp) begin
            failRun($sformatf("CHECK FAILED hit (no memReqCyc): got %h, expected %h", got, exp));
        end
    endtask

    task automatic applyReset();
        @(negedge rwArbiterCacheBus);
        reset = 1'b1;
        repeat (resetCycles) @(negedge rwArbiterCacheBus);
        reset = 1'b0;
    endtask

    // One core read, watching the memory side until the response strobe
    task automatic runRead(input cachePkg::addrT addr, output cachePkg::wordT data,
                           output bit sawMem, output cachePkg::addrT memAddr);
        sawMem = 1'b0;
        memAddr = '0;
        @(negedge rwArbiterCacheBus);
        reqCyc = 1'b1;
        reqAddr = addr;
        @(negedge rwArbiterCacheBus);
        while (!reqAck) @(negedge rwArbiterCacheBus);
        reqCyc = 1'b0;
        @(negedge rwArbiterCacheBus);
        while (!respCyc) begin
            if (memReqCyc) begin
                sawMem = 1'b1;
                memAddr = memReqAddr;
            end
            @(negedge rwArbiterCacheBus);
        end
        data = respData;
    endtask

    initial begin
        cachePkg::wordT gotWord;
        bit sawMem;
        cachePkg::addrT memAddr;
        reset = 1'b1;
        reqCyc = 1'b0;
        reqAddr = '0;
        applyReset();
        for (int i = 0; i < numSteps; i++) begin
            if (steps[i].doReset) begin
                applyReset();
            end
            runRead(steps[i].addr, gotWord, sawMem, memAddr);
            checkWord("respData", gotWord, expectedWord(steps[i].addr));
            checkHit(!sawMem, steps[i].expHit);
            // Fill address only exists on a miss
            if (sawMem) begin
                checkAddr("memReqAddr", memAddr, lineAddress(steps[i].addr));
            end
        end
        $display("Testbench passed");
        $finish;
    end

    // Generous per-read budget covers the slowest random memory timing
    initial begin
        #((numSteps * 60 + resetCycles) * clkPeriod);
        failRun("Timed out waiting for the DUT to finish a read");
    end

endmodule

//--- setAssocDataCache.f
src/cachePkg.sv
src/cacheIfs.sv
src/coreSidePort.sv
src/cacheController.sv
src/tagStore.sv
src/dataStore.sv
src/lineFetcher.sv
src/setAssocDataCache.sv
verification/cacheMemModel.sv
verification/cacheAssert_assert.sv
verification/tbSetAssocDataCache.sv

//--- build.sh
#!/bin/sh
# Build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module tbSetAssocDataCache \
    -f setAssocDataCache.f \
    -Mdir obj_dir
./obj_dir/VtbSetAssocDataCache
